/* include/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// word geometry
`define CACHE_DATA_W 32
`define CACHE_NBYTES 4

// front-end word address, split into tag, line index and word offset
`define CACHE_FE_ADDR_W 12
`define CACHE_NLINES_W 4
`define CACHE_WORD_OFFSET_W 2
`define CACHE_TAG_W (`CACHE_FE_ADDR_W - `CACHE_NLINES_W - `CACHE_WORD_OFFSET_W)

// memory side is byte addressed
`define CACHE_BE_ADDR_W 16

`define CACHE_WTB_DEPTH_W 2
`define CACHE_CTRL_ADDR_W 3

`endif

/* source/cache_pkg.sv */
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

   typedef logic [`CACHE_DATA_W-1:0]        word_t;
   typedef logic [`CACHE_NBYTES-1:0]        strb_t;
   typedef logic [`CACHE_FE_ADDR_W-1:0]     fe_addr_t;
   typedef logic [`CACHE_TAG_W-1:0]         tag_t;
   typedef logic [`CACHE_NLINES_W-1:0]      index_t;
   typedef logic [`CACHE_WORD_OFFSET_W-1:0] offset_t;
   typedef logic [`CACHE_BE_ADDR_W-1:0]     be_addr_t;
   typedef logic [`CACHE_CTRL_ADDR_W-1:0]   ctrl_addr_t;

   // request held by the front end for the whole access
   typedef struct packed {
      fe_addr_t addr;
      word_t    wdata;
      strb_t    wstrb;
      logic     write;
   } fe_req_t;

   typedef struct packed {
      fe_addr_t addr;
      word_t    data;
      strb_t    strb;
   } wtb_entry_t;

   typedef struct packed {
      logic read_hit;
      logic read_miss;
      logic write_hit;
      logic write_miss;
   } cache_events_t;

   typedef enum logic [1:0] {MEM_IDLE, MEM_DRAIN, MEM_FILL, MEM_RESPOND} mem_state_e;
   typedef enum logic [1:0] {BE_IDLE, BE_WRITE, BE_READ} be_state_e;

   // control register map
   localparam ctrl_addr_t CTRL_READ_HITS   = 3'd0;
   localparam ctrl_addr_t CTRL_READ_MISSES = 3'd1;
   localparam ctrl_addr_t CTRL_WRITE_HITS  = 3'd2;
   localparam ctrl_addr_t CTRL_WRITE_MISSES = 3'd3;
   localparam ctrl_addr_t CTRL_STATUS      = 3'd4;
   localparam ctrl_addr_t CTRL_INVALIDATE  = 3'd5;
   localparam ctrl_addr_t CTRL_CLEAR       = 3'd6;

endpackage

`default_nettype wire

/* source/cache_front_end.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_front_end (
   input  wire                      clk_i,
   input  wire                      arst_n_i,
   // host port, top address bit selects the control registers
   input  wire                      req_i,
   input  wire [`CACHE_FE_ADDR_W:0] addr_i,
   input  cache_pkg::word_t         wdata_i,
   input  cache_pkg::strb_t         wstrb_i,
   output logic                     ack_o,
   output cache_pkg::word_t         rdata_o,
   // registered request shared by memory and control
   output cache_pkg::fe_req_t       fe_req_o,
   output logic                     mem_req_o,
   input  wire                      mem_ack_i,
   input  cache_pkg::word_t         mem_rdata_i,
   output logic                     ctrl_req_o,
   input  wire                      ctrl_ack_i,
   input  cache_pkg::word_t         ctrl_rdata_i
);

   logic ctrl_sel;

   assign ctrl_sel = addr_i[`CACHE_FE_ADDR_W];

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mem_req_o  <= 1'b0;
         ctrl_req_o <= 1'b0;
      end else begin
         mem_req_o  <= req_i && !ctrl_sel;
         ctrl_req_o <= req_i && ctrl_sel;
      end
   end

   // request stays stable until the ack, host does not issue before that
   always_ff @(posedge clk_i) begin
      if (req_i) begin
         fe_req_o.addr  <= addr_i[`CACHE_FE_ADDR_W-1:0];
         fe_req_o.wdata <= wdata_i;
         fe_req_o.wstrb <= wstrb_i;
         fe_req_o.write <= |wstrb_i;
      end
   end

   // only one side answers per access
   assign ack_o   = mem_ack_i || ctrl_ack_i;
   assign rdata_o = ctrl_ack_i ? ctrl_rdata_i : mem_rdata_i;

endmodule

`default_nettype wire

/* source/cache_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_memory (
   input  wire                     clk_i,
   input  wire                     arst_n_i,
   input  cache_pkg::fe_req_t      fe_req_i,
   input  wire                     req_i,
   output logic                    ack_o,
   output cache_pkg::word_t        rdata_o,
   input  wire                     invalidate_i,
   // write-through buffer
   input  wire                     wtb_full_i,
   input  wire                     wtb_empty_i,
   output logic                    wtb_push_o,
   output cache_pkg::wtb_entry_t   wtb_entry_o,
   // line fill from the back end
   output logic                    fill_req_o,
   output cache_pkg::fe_addr_t     fill_addr_o,
   input  wire                     fill_valid_i,
   input  cache_pkg::offset_t      fill_offset_i,
   input  cache_pkg::word_t        fill_data_i,
   input  wire                     fill_done_i,
   output cache_pkg::cache_events_t events_o
);

   localparam int NLINES = 2 ** `CACHE_NLINES_W;
   localparam int NWORDS = 2 ** (`CACHE_NLINES_W + `CACHE_WORD_OFFSET_W);

   cache_pkg::mem_state_e state_q;
   logic                  pend_q;
   logic [NLINES-1:0]     valid_q;
   cache_pkg::tag_t       tag_mem [NLINES];
   cache_pkg::word_t      data_mem [NWORDS];

   cache_pkg::tag_t    req_tag;
   cache_pkg::index_t  req_idx;
   cache_pkg::offset_t req_off;
   logic               idle_req;
   logic               hit;
   logic               do_write;
   logic               do_read;
   logic               fill_end;

   assign req_tag = fe_req_i.addr[`CACHE_FE_ADDR_W-1 -: `CACHE_TAG_W];
   assign req_idx = fe_req_i.addr[`CACHE_WORD_OFFSET_W +: `CACHE_NLINES_W];
   assign req_off = fe_req_i.addr[`CACHE_WORD_OFFSET_W-1:0];

   // a write stalled on a full buffer is retried from pend_q
   assign idle_req = (state_q == cache_pkg::MEM_IDLE) && (req_i || pend_q);
   assign hit      = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
   assign do_write = idle_req && fe_req_i.write && !wtb_full_i;
   assign do_read  = idle_req && !fe_req_i.write;
   assign fill_end = (state_q == cache_pkg::MEM_FILL) && fill_done_i;

   // every write goes through, hit or miss
   assign wtb_push_o        = do_write;
   assign wtb_entry_o.addr  = fe_req_i.addr;
   assign wtb_entry_o.data  = fe_req_i.wdata;
   assign wtb_entry_o.strb  = fe_req_i.wstrb;

   assign fill_req_o  = (state_q == cache_pkg::MEM_FILL);
   assign fill_addr_o = {req_tag, req_idx, {`CACHE_WORD_OFFSET_W{1'b0}}};

   assign events_o.read_hit   = do_read && hit;
   assign events_o.read_miss  = do_read && !hit;
   assign events_o.write_hit  = do_write && hit;
   assign events_o.write_miss = do_write && !hit;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= cache_pkg::MEM_IDLE;
         pend_q  <= 1'b0;
         ack_o   <= 1'b0;
         valid_q <= '0;
      end else begin
         pend_q <= idle_req && fe_req_i.write && wtb_full_i;
         ack_o  <= do_write || (do_read && hit) || fill_end;
         case (state_q)
            cache_pkg::MEM_IDLE:
               if (do_read && !hit) state_q <= cache_pkg::MEM_DRAIN;
            // older writes must reach memory before the line is fetched
            cache_pkg::MEM_DRAIN:
               if (wtb_empty_i) state_q <= cache_pkg::MEM_FILL;
            cache_pkg::MEM_FILL:
               if (fill_done_i) begin
                  valid_q[req_idx] <= 1'b1;
                  state_q          <= cache_pkg::MEM_RESPOND;
               end
            default:
               state_q <= cache_pkg::MEM_IDLE;
         endcase
         // flash clear wins over a fill ending in the same cycle
         if (invalidate_i) valid_q <= '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_write && hit) begin
         for (int b = 0; b < `CACHE_NBYTES; b++) begin
            if (fe_req_i.wstrb[b])
               data_mem[{req_idx, req_off}][8*b +: 8] <= fe_req_i.wdata[8*b +: 8];
         end
      end
      if (fill_req_o && fill_valid_i) data_mem[{req_idx, fill_offset_i}] <= fill_data_i;
      if (fill_end) tag_mem[req_idx] <= req_tag;
      if (do_read && hit) rdata_o <= data_mem[{req_idx, req_off}];
      // requested word may be the one arriving right now
      if (fill_end)
         rdata_o <= (fill_offset_i == req_off) ? fill_data_i : data_mem[{req_idx, req_off}];
   end

endmodule

`default_nettype wire

/* source/cache_write_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_write_buffer #(
   parameter int DEPTH_W = `CACHE_WTB_DEPTH_W
) (
   input  wire                   clk_i,
   input  wire                   arst_n_i,
   input  wire                   push_i,
   input  cache_pkg::wtb_entry_t entry_i,
   input  wire                   pop_i,
   output cache_pkg::wtb_entry_t entry_o,
   output logic                  empty_o,
   output logic                  full_o
);

   localparam int DEPTH = 2 ** DEPTH_W;

   cache_pkg::wtb_entry_t mem [DEPTH];
   logic [DEPTH_W-1:0]    wr_ptr_q;
   logic [DEPTH_W-1:0]    rd_ptr_q;
   logic [DEPTH_W:0]      count_q;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
         if (pop_i) rd_ptr_q <= rd_ptr_q + 1'b1;
         if (push_i && !pop_i) count_q <= count_q + 1'b1;
         else if (pop_i && !push_i) count_q <= count_q - 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i) mem[wr_ptr_q] <= entry_i;
   end

   // head entry is visible without a read strobe
   assign entry_o = mem[rd_ptr_q];
   assign empty_o = (count_q == '0);
   assign full_o  = count_q[DEPTH_W];

endmodule

`default_nettype wire

/* source/cache_back_end.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_back_end (
   input  wire                   clk_i,
   input  wire                   arst_n_i,
   // write-through buffer head
   input  cache_pkg::wtb_entry_t wtb_entry_i,
   input  wire                   wtb_empty_i,
   output logic                  wtb_pop_o,
   // line fill
   input  wire                   fill_req_i,
   input  cache_pkg::fe_addr_t   fill_addr_i,
   output logic                  fill_valid_o,
   output cache_pkg::offset_t    fill_offset_o,
   output cache_pkg::word_t      fill_data_o,
   output logic                  fill_done_o,
   // memory-side port
   output logic                  be_req_o,
   output cache_pkg::be_addr_t   be_addr_o,
   output cache_pkg::word_t      be_wdata_o,
   output cache_pkg::strb_t      be_wstrb_o,
   input  cache_pkg::word_t      be_rdata_i,
   input  wire                   be_ack_i
);

   localparam int NBYTES_W = $clog2(`CACHE_NBYTES);

   cache_pkg::be_state_e state_q;
   cache_pkg::offset_t   cnt_q;
   logic                 issue;

   function automatic cache_pkg::be_addr_t byte_addr(input cache_pkg::fe_addr_t waddr);
      byte_addr = cache_pkg::be_addr_t'({waddr, {NBYTES_W{1'b0}}});
   endfunction

   // one idle cycle between words, then the next access goes out
   assign issue = (state_q != cache_pkg::BE_IDLE) && !be_req_o;

   assign wtb_pop_o     = (state_q == cache_pkg::BE_WRITE) && be_ack_i;
   assign fill_valid_o  = (state_q == cache_pkg::BE_READ) && be_ack_i;
   assign fill_offset_o = cnt_q;
   assign fill_data_o   = be_rdata_i;
   assign fill_done_o   = fill_valid_o && (cnt_q == '1);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q  <= cache_pkg::BE_IDLE;
         cnt_q    <= '0;
         be_req_o <= 1'b0;
      end else begin
         if (issue) be_req_o <= 1'b1;
         else if (be_ack_i) be_req_o <= 1'b0;
         case (state_q)
            // fill first, memory drained the buffer before asking
            cache_pkg::BE_IDLE:
               if (fill_req_i) begin
                  cnt_q   <= '0;
                  state_q <= cache_pkg::BE_READ;
               end else if (!wtb_empty_i) begin
                  state_q <= cache_pkg::BE_WRITE;
               end
            cache_pkg::BE_WRITE:
               if (be_ack_i) state_q <= cache_pkg::BE_IDLE;
            cache_pkg::BE_READ:
               if (be_ack_i) begin
                  cnt_q <= cnt_q + 1'b1;
                  if (fill_done_o) state_q <= cache_pkg::BE_IDLE;
               end
            default:
               state_q <= cache_pkg::BE_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (issue && state_q == cache_pkg::BE_READ) begin
         be_addr_o  <= byte_addr({fill_addr_i[`CACHE_FE_ADDR_W-1:`CACHE_WORD_OFFSET_W], cnt_q});
         be_wstrb_o <= '0;
      end else if (issue) begin
         be_addr_o  <= byte_addr(wtb_entry_i.addr);
         be_wdata_o <= wtb_entry_i.data;
         be_wstrb_o <= wtb_entry_i.strb;
      end
   end

endmodule

`default_nettype wire

/* source/cache_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_control (
   input  wire                      clk_i,
   input  wire                      arst_n_i,
   input  wire                      req_i,
   input  cache_pkg::fe_req_t       fe_req_i,
   input  cache_pkg::cache_events_t events_i,
   input  wire                      wtb_empty_i,
   input  wire                      wtb_full_i,
   output logic                     ack_o,
   output cache_pkg::word_t         rdata_o,
   output logic                     invalidate_o
);

   cache_pkg::ctrl_addr_t reg_sel;
   cache_pkg::word_t      cnt_q [4];
   logic [3:0]            ev;
   logic                  wr;

   assign reg_sel = fe_req_i.addr[`CACHE_CTRL_ADDR_W-1:0];
   assign wr      = req_i && fe_req_i.write;
   // bit i lines up with counter register i
   assign ev = {events_i.write_miss, events_i.write_hit, events_i.read_miss, events_i.read_hit};

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o        <= 1'b0;
         invalidate_o <= 1'b0;
         for (int i = 0; i < 4; i++) cnt_q[i] <= '0;
      end else begin
         ack_o        <= req_i;
         invalidate_o <= wr && (reg_sel == cache_pkg::CTRL_INVALIDATE);
         for (int i = 0; i < 4; i++) begin
            if (wr && reg_sel == cache_pkg::CTRL_CLEAR) cnt_q[i] <= '0;
            else if (ev[i]) cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (req_i) begin
         if (reg_sel < cache_pkg::CTRL_STATUS) rdata_o <= cnt_q[reg_sel[1:0]];
         else if (reg_sel == cache_pkg::CTRL_STATUS)
            rdata_o <= cache_pkg::word_t'({wtb_full_i, wtb_empty_i});
         else rdata_o <= '0;
      end
   end

endmodule

`default_nettype wire

/* source/cache_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_top (
   input  wire                      clk_i,
   input  wire                      arst_n_i,
   // processor side
   input  wire                      req_i,
   input  wire [`CACHE_FE_ADDR_W:0] addr_i,
   input  cache_pkg::word_t         wdata_i,
   input  cache_pkg::strb_t         wstrb_i,
   output cache_pkg::word_t         rdata_o,
   output logic                     ack_o,
   // memory side
   output logic                     be_req_o,
   output cache_pkg::be_addr_t      be_addr_o,
   output cache_pkg::word_t         be_wdata_o,
   output cache_pkg::strb_t         be_wstrb_o,
   input  cache_pkg::word_t         be_rdata_i,
   input  wire                      be_ack_i,
   // chain to other cache levels
   input  wire                      invalidate_i,
   output logic                     invalidate_o,
   input  wire                      wtb_empty_i,
   output logic                     wtb_empty_o
);

   cache_pkg::fe_req_t       fe_req;
   cache_pkg::word_t         mem_rdata;
   cache_pkg::word_t         ctrl_rdata;
   cache_pkg::cache_events_t events;
   cache_pkg::wtb_entry_t    wtb_in;
   cache_pkg::wtb_entry_t    wtb_out;
   cache_pkg::fe_addr_t      fill_addr;
   cache_pkg::offset_t       fill_offset;
   cache_pkg::word_t         fill_data;
   logic mem_req, mem_ack, ctrl_req, ctrl_ack, ctrl_invalidate;
   logic wtb_push, wtb_pop, wtb_full, wtb_empty;
   logic fill_req, fill_valid, fill_done;

   assign invalidate_o = ctrl_invalidate || invalidate_i;
   assign wtb_empty_o  = wtb_empty && wtb_empty_i;

   cache_front_end front_end (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .req_i(req_i), .addr_i(addr_i), .wdata_i(wdata_i), .wstrb_i(wstrb_i),
      .ack_o(ack_o), .rdata_o(rdata_o), .fe_req_o(fe_req),
      .mem_req_o(mem_req), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
      .ctrl_req_o(ctrl_req), .ctrl_ack_i(ctrl_ack), .ctrl_rdata_i(ctrl_rdata)
   );

   cache_memory memory (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .fe_req_i(fe_req), .req_i(mem_req), .ack_o(mem_ack), .rdata_o(mem_rdata),
      .invalidate_i(invalidate_o),
      .wtb_full_i(wtb_full), .wtb_empty_i(wtb_empty),
      .wtb_push_o(wtb_push), .wtb_entry_o(wtb_in),
      .fill_req_o(fill_req), .fill_addr_o(fill_addr), .fill_valid_i(fill_valid),
      .fill_offset_i(fill_offset), .fill_data_i(fill_data), .fill_done_i(fill_done),
      .events_o(events)
   );

   cache_write_buffer #(.DEPTH_W(`CACHE_WTB_DEPTH_W)) write_buffer (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .push_i(wtb_push), .entry_i(wtb_in), .pop_i(wtb_pop),
      .entry_o(wtb_out), .empty_o(wtb_empty), .full_o(wtb_full)
   );

   cache_back_end back_end (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .wtb_entry_i(wtb_out), .wtb_empty_i(wtb_empty), .wtb_pop_o(wtb_pop),
      .fill_req_i(fill_req), .fill_addr_i(fill_addr), .fill_valid_o(fill_valid),
      .fill_offset_o(fill_offset), .fill_data_o(fill_data), .fill_done_o(fill_done),
      .be_req_o(be_req_o), .be_addr_o(be_addr_o), .be_wdata_o(be_wdata_o),
      .be_wstrb_o(be_wstrb_o), .be_rdata_i(be_rdata_i), .be_ack_i(be_ack_i)
   );

   cache_control control (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .req_i(ctrl_req), .fe_req_i(fe_req), .events_i(events),
      .wtb_empty_i(wtb_empty), .wtb_full_i(wtb_full),
      .ack_o(ctrl_ack), .rdata_o(ctrl_rdata), .invalidate_o(ctrl_invalidate)
   );

endmodule

`default_nettype wire

/* testbench/backend_memory_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module backend_memory_model (
   input  wire                 clk_i,
   input  wire                 arst_n_i,
   input  wire                 req_i,
   input  cache_pkg::be_addr_t addr_i,
   input  cache_pkg::word_t    wdata_i,
   input  cache_pkg::strb_t    wstrb_i,
   // adds eight cycles to every acknowledge
   input  wire                 slow_i,
   output cache_pkg::word_t    rdata_o,
   output logic                ack_o
);

   localparam int NBYTES_W = $clog2(`CACHE_NBYTES);
   localparam int NWORDS   = 2 ** (`CACHE_BE_ADDR_W - NBYTES_W);

   cache_pkg::word_t                    mem [NWORDS];
   integer                              seed;
   integer                              rnd;
   logic                                busy_q;
   logic [3:0]                          wait_q;
   logic [`CACHE_BE_ADDR_W-NBYTES_W-1:0] widx;

   assign widx = addr_i[`CACHE_BE_ADDR_W-1:NBYTES_W];

   // every word starts as its own word address with a marker in the upper half
   initial begin
      seed = 24;
      for (int i = 0; i < NWORDS; i++) begin
         mem[i] = 32'(i) ^ 32'hA5A5_0000;
      end
   end

   always @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         busy_q  <= 1'b0;
         wait_q  <= '0;
         ack_o   <= 1'b0;
         rdata_o <= '0;
      end else begin
         ack_o <= 1'b0;
         if (ack_o) begin
            // request drops on this edge, do not start again
            busy_q <= 1'b0;
         end else if (req_i && !busy_q) begin
            rnd = $random(seed);
            busy_q <= 1'b1;
            wait_q <= {2'b00, rnd[1:0]} + (slow_i ? 4'd8 : 4'd0);
         end else if (busy_q && wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
         end else if (busy_q) begin
            ack_o   <= 1'b1;
            rdata_o <= mem[widx];
            for (int b = 0; b < `CACHE_NBYTES; b++) begin
               if (wstrb_i[b]) mem[widx][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

/* testbench/cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module cache_tb;

   localparam int NADDR         = 2 ** `CACHE_FE_ADDR_W;
   localparam int NLINES        = 2 ** `CACHE_NLINES_W;
   localparam int ACK_TIMEOUT   = 500;
   localparam int DRAIN_TIMEOUT = 2000;

   logic                      clk;
   logic                      arst_n;
   logic                      req;
   logic [`CACHE_FE_ADDR_W:0] addr;
   cache_pkg::word_t          wdata;
   cache_pkg::strb_t          wstrb;
   cache_pkg::word_t          rdata;
   logic                      ack;
   logic                      be_req;
   cache_pkg::be_addr_t       be_addr;
   cache_pkg::word_t          be_wdata;
   cache_pkg::strb_t          be_wstrb;
   cache_pkg::word_t          be_rdata;
   logic                      be_ack;
   logic                      invalidate_in;
   logic                      invalidate_out;
   logic                      empty_in;
   logic                      empty_out;
   logic                      slow;

   // expected state of the cache and the memory behind it
   cache_pkg::word_t shadow [NADDR];
   logic             line_valid [NLINES];
   cache_pkg::tag_t  line_tag [NLINES];
   // read hits, read misses, write hits, write misses
   int unsigned      tally [4];

   initial clk = 1'b0;
   always #20 clk = ~clk;

   cache_top dut (
      .clk_i(clk), .arst_n_i(arst_n),
      .req_i(req), .addr_i(addr), .wdata_i(wdata), .wstrb_i(wstrb),
      .rdata_o(rdata), .ack_o(ack),
      .be_req_o(be_req), .be_addr_o(be_addr), .be_wdata_o(be_wdata),
      .be_wstrb_o(be_wstrb), .be_rdata_i(be_rdata), .be_ack_i(be_ack),
      .invalidate_i(invalidate_in), .invalidate_o(invalidate_out),
      .wtb_empty_i(empty_in), .wtb_empty_o(empty_out)
   );

   backend_memory_model memory_model (
      .clk_i(clk), .arst_n_i(arst_n),
      .req_i(be_req), .addr_i(be_addr), .wdata_i(be_wdata), .wstrb_i(be_wstrb),
      .slow_i(slow), .rdata_o(be_rdata), .ack_o(be_ack)
   );

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input cache_pkg::word_t got,
                              input cache_pkg::word_t exp);
      assert (got === exp)
      else abort_run($sformatf("Fail at %0t ns: %s gave %h, expected %h", $time, what, got, exp));
   endtask

   task automatic check_cond(input string what, input logic cond);
      assert (cond === 1'b1)
      else abort_run($sformatf("Fail at %0t ns: %s", $time, what));
   endtask

   function automatic cache_pkg::word_t initial_word(input cache_pkg::fe_addr_t a);
      return 32'(a) ^ 32'hA5A5_0000;
   endfunction

   function automatic cache_pkg::word_t merge_bytes(input cache_pkg::word_t old,
                                                    input cache_pkg::word_t new_data,
                                                    input cache_pkg::strb_t strb);
      cache_pkg::word_t res;
      res = old;
      for (int b = 0; b < `CACHE_NBYTES; b++) begin
         if (strb[b]) res[8*b +: 8] = new_data[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [`CACHE_FE_ADDR_W:0] ctrl_addr(input cache_pkg::ctrl_addr_t r);
      return {1'b1, {(`CACHE_FE_ADDR_W - `CACHE_CTRL_ADDR_W){1'b0}}, r};
   endfunction

   task automatic forget_lines();
      for (int i = 0; i < NLINES; i++) line_valid[i] = 1'b0;
   endtask

   // one host access with its latency in falling edges
   task automatic bus_access(input logic [`CACHE_FE_ADDR_W:0] a, input cache_pkg::word_t wd,
                             input cache_pkg::strb_t ws, output cache_pkg::word_t rd,
                             output int lat);
      req   = 1'b1;
      addr  = a;
      wdata = wd;
      wstrb = ws;
      lat   = 0;
      do begin
         @(negedge clk);
         req = 1'b0;
         lat++;
         if (lat > ACK_TIMEOUT)
            abort_run($sformatf("no ack_o within %0d cycles for address %h", ACK_TIMEOUT, a));
      end while (!ack);
      rd = rdata;
   endtask

   task automatic read_check(input cache_pkg::fe_addr_t a);
      cache_pkg::index_t idx;
      cache_pkg::tag_t   tag;
      logic              hit;
      cache_pkg::word_t  rd;
      int                lat;
      idx = a[`CACHE_WORD_OFFSET_W +: `CACHE_NLINES_W];
      tag = a[`CACHE_FE_ADDR_W-1 -: `CACHE_TAG_W];
      hit = line_valid[idx] && (line_tag[idx] == tag);
      bus_access({1'b0, a}, '0, '0, rd, lat);
      check_value($sformatf("read of %h", a), rd, shadow[a]);
      if (hit) begin
         check_cond($sformatf("read hit of %h took %0d cycles", a, lat), lat == 2);
         tally[0]++;
      end else begin
         check_cond($sformatf("read miss of %h took only %0d cycles", a, lat), lat > 2);
         tally[1]++;
         line_valid[idx] = 1'b1;
         line_tag[idx]   = tag;
      end
   endtask

   task automatic write_check(input cache_pkg::fe_addr_t a, input cache_pkg::word_t d,
                              input cache_pkg::strb_t s, input logic fast, output int lat);
      cache_pkg::index_t idx;
      logic              hit;
      cache_pkg::word_t  rd;
      idx = a[`CACHE_WORD_OFFSET_W +: `CACHE_NLINES_W];
      hit = line_valid[idx] && (line_tag[idx] == a[`CACHE_FE_ADDR_W-1 -: `CACHE_TAG_W]);
      bus_access({1'b0, a}, d, s, rd, lat);
      if (fast) check_cond($sformatf("write to %h took %0d cycles", a, lat), lat == 2);
      shadow[a] = merge_bytes(shadow[a], d, s);
      if (hit) tally[2]++;
      else tally[3]++;
   endtask

   task automatic ctrl_read(input cache_pkg::ctrl_addr_t r, output cache_pkg::word_t rd);
      int lat;
      bus_access(ctrl_addr(r), '0, '0, rd, lat);
      check_cond($sformatf("control read %0d took %0d cycles", r, lat), lat == 2);
   endtask

   task automatic ctrl_write(input cache_pkg::ctrl_addr_t r);
      cache_pkg::word_t rd;
      int               lat;
      bus_access(ctrl_addr(r), 32'h1, 4'hF, rd, lat);
      check_cond($sformatf("control write %0d took %0d cycles", r, lat), lat == 2);
      if (r == cache_pkg::CTRL_INVALIDATE) forget_lines();
      if (r == cache_pkg::CTRL_CLEAR) begin
         for (int i = 0; i < 4; i++) tally[i] = 0;
      end
   endtask

   task automatic check_counters();
      cache_pkg::word_t rd;
      for (int i = 0; i < 4; i++) begin
         ctrl_read(cache_pkg::ctrl_addr_t'(i), rd);
         check_value($sformatf("counter register %0d", i), rd, 32'(tally[i]));
      end
   endtask

   task automatic wait_drained();
      int n;
      n = 0;
      while (!empty_out) begin
         @(negedge clk);
         n++;
         if (n > DRAIN_TIMEOUT) abort_run("write buffer did not drain before the timeout");
      end
   endtask

   task automatic miss_then_hit();
      read_check(12'h040);
      read_check(12'h041);
      read_check(12'h043);
   endtask

   task automatic byte_strobe_writes();
      int lat;
      write_check(12'h041, 32'h1122_3344, 4'b0001, 1'b1, lat);
      write_check(12'h041, 32'h5566_7788, 4'b0110, 1'b1, lat);
      write_check(12'h042, 32'hDEAD_BEEF, 4'b1000, 1'b1, lat);
      read_check(12'h041);
      read_check(12'h042);
      wait_drained();
      ctrl_write(cache_pkg::CTRL_INVALIDATE);
      // merged words now come back from the memory model
      read_check(12'h041);
      read_check(12'h042);
   endtask

   task automatic write_miss_no_allocate();
      int lat;
      write_check(12'h200, 32'hCAFE_F00D, 4'hF, 1'b1, lat);
      read_check(12'h200);
      read_check(12'h040);
   endtask

   task automatic counter_and_status();
      cache_pkg::word_t rd;
      check_counters();
      wait_drained();
      ctrl_read(cache_pkg::CTRL_STATUS, rd);
      check_value("status register", rd, 32'h1);
      ctrl_write(cache_pkg::CTRL_CLEAR);
      check_counters();
   endtask

   task automatic invalidate_and_chain();
      read_check(12'h080);
      read_check(12'h081);
      invalidate_in = 1'b1;
      @(negedge clk);
      check_cond("invalidate_o did not follow invalidate_i", invalidate_out);
      invalidate_in = 1'b0;
      forget_lines();
      read_check(12'h080);
      check_counters();
      empty_in = 1'b0;
      @(negedge clk);
      check_cond("wtb_empty_o stayed high with wtb_empty_i low", !empty_out);
      empty_in = 1'b1;
      @(negedge clk);
      check_cond("wtb_empty_o low with an empty buffer", empty_out);
   endtask

   task automatic write_back_pressure();
      cache_pkg::fe_addr_t a;
      int                  lat;
      int                  max_lat;
      read_check(12'h300);
      slow    = 1'b1;
      max_lat = 0;
      for (int i = 0; i < 8; i++) begin
         a = 12'h300 + 12'(3 * i);
         write_check(a, 32'hC0DE_0000 ^ (32'(i) << 4), 4'(i + 1), 1'b0, lat);
         if (lat > max_lat) max_lat = lat;
      end
      check_cond("burst never stalled on a full write buffer", max_lat > 2);
      wait_drained();
      slow = 1'b0;
      ctrl_write(cache_pkg::CTRL_INVALIDATE);
      for (int i = 0; i < 8; i++) read_check(12'h300 + 12'(3 * i));
   endtask

   initial begin
      arst_n        = 1'b0;
      req           = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      invalidate_in = 1'b0;
      empty_in      = 1'b1;
      slow          = 1'b0;
      for (int i = 0; i < NADDR; i++) shadow[i] = initial_word(cache_pkg::fe_addr_t'(i));
      forget_lines();
      for (int i = 0; i < 4; i++) tally[i] = 0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_cond("ack_o high after reset", !ack);
      check_cond("be_req_o high after reset", !be_req);
      check_cond("invalidate_o high after reset", !invalidate_out);
      check_cond("wtb_empty_o low after reset", empty_out);
      miss_then_hit();
      byte_strobe_writes();
      write_miss_no_allocate();
      counter_and_status();
      invalidate_and_chain();
      write_back_pressure();
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/cache_pkg.sv
source/cache_front_end.sv
source/cache_memory.sv
source/cache_write_buffer.sv
source/cache_back_end.sv
source/cache_control.sv
source/cache_top.sv
testbench/backend_memory_model.sv
testbench/cache_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cache_tb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
